// ==== cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath and memory geometry
    ////////////////////////////////////////////////////////////

    localparam int data_width   = 16;
    localparam int addr_width   = 11;
    localparam int opcode_width = 5;
    localparam int ram_depth    = 2048;

    // Instruction word is opcode over operand
    typedef enum logic [opcode_width-1:0] {
        op_hlt  = 5'd0,
        op_sto  = 5'd1,
        op_ld   = 5'd2,
        op_ldi  = 5'd3,
        op_add  = 5'd4,
        op_addi = 5'd5,
        op_sub  = 5'd6,
        op_subi = 5'd7
    } cpu_opcode_e;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute
    } cpu_state_e;

    // One access to the data RAM
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic                  wr;
    } dmem_req_t;

endpackage

// ==== host_pkg.sv ====
package host_pkg;

    ////////////////////////////////////////////////////////////
    // Host link encodings
    ////////////////////////////////////////////////////////////

    localparam int byte_width  = 8;
    localparam int reply_bytes = 3;

    typedef enum logic [byte_width-1:0] {
        cmd_run = 8'h52
    } host_cmd_e;

    typedef enum logic [byte_width-1:0] {
        rep_bad_cmd = 8'hEE
    } host_reply_e;

    typedef enum logic [2:0] {
        hs_idle,
        hs_arg_lo,
        hs_arg_hi,
        hs_load,
        hs_run,
        hs_send
    } host_state_e;

    // Result sent back after a run
    typedef struct packed {
        logic [cpu_pkg::data_width-1:0] acc;
        logic [byte_width-1:0]          cycles;
    } host_report_t;

endpackage

// ==== accumulator_cpu.sv ====
module accumulator_cpu (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  logic [cpu_pkg::data_width-1:0] instr,
    input  logic [cpu_pkg::data_width-1:0] rdata,
    output logic [cpu_pkg::addr_width-1:0] prog_addr,
    output cpu_pkg::dmem_req_t             dmem,
    output logic [cpu_pkg::data_width-1:0] acc,
    output logic                           busy,
    output logic                           done
);

    localparam int ext_width = cpu_pkg::data_width - cpu_pkg::addr_width;

    cpu_pkg::cpu_state_e             state;
    logic [cpu_pkg::addr_width-1:0]  pc;
    cpu_pkg::cpu_opcode_e            opcode_q;
    logic [cpu_pkg::addr_width-1:0]  operand_q;

    logic [cpu_pkg::data_width-1:0]  imm;
    logic [cpu_pkg::data_width-1:0]  src;
    logic [cpu_pkg::data_width-1:0]  alu_out;
    logic                            imm_sel;
    logic                            sub_sel;

    ////////////////////////////////////////////////////////////
    // Add/subtract unit
    ////////////////////////////////////////////////////////////

    assign imm = {{ext_width{operand_q[cpu_pkg::addr_width-1]}}, operand_q};

    // Immediate forms take the operand field, the rest read the RAM
    assign imm_sel = (opcode_q == cpu_pkg::op_ldi) ||
                     (opcode_q == cpu_pkg::op_addi) ||
                     (opcode_q == cpu_pkg::op_subi);
    assign sub_sel = (opcode_q == cpu_pkg::op_sub) ||
                     (opcode_q == cpu_pkg::op_subi);

    assign src     = imm_sel ? imm : rdata;
    assign alu_out = sub_sel ? (acc - src) : (acc + src);

    ////////////////////////////////////////////////////////////
    // Memory ports
    ////////////////////////////////////////////////////////////

    // ROM address held for the whole instruction
    assign prog_addr = pc;

    always_comb begin
        dmem.addr  = operand_q;
        dmem.wdata = acc;
        dmem.wr    = (state == cpu_pkg::st_execute) && (opcode_q == cpu_pkg::op_sto);
    end

    assign busy = (state != cpu_pkg::st_idle);

    ////////////////////////////////////////////////////////////
    // Controller
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cpu_pkg::st_idle;
            pc    <= '0;
            acc   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                cpu_pkg::st_idle: begin
                    if (start) begin
                        pc    <= '0;
                        state <= cpu_pkg::st_fetch;
                    end
                end
                // ROM registers the word at the end of this cycle
                cpu_pkg::st_fetch: begin
                    state <= cpu_pkg::st_decode;
                end
                cpu_pkg::st_decode: begin
                    state <= cpu_pkg::st_execute;
                end
                cpu_pkg::st_execute: begin
                    case (opcode_q)
                        cpu_pkg::op_ld,
                        cpu_pkg::op_ldi: acc <= src;
                        cpu_pkg::op_add,
                        cpu_pkg::op_addi,
                        cpu_pkg::op_sub,
                        cpu_pkg::op_subi: acc <= alu_out;
                        default: acc <= acc;
                    endcase
                    if (opcode_q == cpu_pkg::op_hlt) begin
                        done  <= 1'b1;
                        state <= cpu_pkg::st_idle;
                    end else begin
                        pc    <= pc + 1'b1;
                        state <= cpu_pkg::st_fetch;
                    end
                end
                default: state <= cpu_pkg::st_idle;
            endcase
        end
    end

    // Instruction fields latched at the end of decode
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::st_decode) begin
            opcode_q  <= cpu_pkg::cpu_opcode_e'(
                instr[cpu_pkg::data_width-1 -: cpu_pkg::opcode_width]);
            operand_q <= instr[cpu_pkg::addr_width-1:0];
        end
    end

endmodule

// ==== program_mem.sv ====
module program_mem (
    input  logic                           clk,
    input  logic [cpu_pkg::addr_width-1:0] addr,
    output logic [cpu_pkg::data_width-1:0] instr
);

    ////////////////////////////////////////////////////////////
    // Instruction ROM
    ////////////////////////////////////////////////////////////

    logic [cpu_pkg::data_width-1:0] rom [cpu_pkg::ram_depth];

    // Contents fixed at elaboration
    initial begin
        $readmemh("program.hex", rom);
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        instr <= rom[addr];
    end

endmodule

// ==== data_mem.sv ====
module data_mem (
    input  logic                           clk,
    input  cpu_pkg::dmem_req_t             req,
    output logic [cpu_pkg::data_width-1:0] rdata
);

    ////////////////////////////////////////////////////////////
    // Single-port data RAM
    ////////////////////////////////////////////////////////////

    logic [cpu_pkg::data_width-1:0] ram [cpu_pkg::ram_depth];

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (req.wr) begin
            ram[req.addr] <= req.wdata;
        end
    end

    // Read follows the address within the cycle
    assign rdata = ram[req.addr];

endmodule

// ==== host_interface.sv ====
module host_interface (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [host_pkg::byte_width-1:0] rx_data,
    input  logic                            rx_valid,
    output logic                            rx_ready,
    output logic [host_pkg::byte_width-1:0] tx_data,
    output logic                            tx_valid,
    input  logic                            tx_ready,
    input  logic [cpu_pkg::data_width-1:0]  acc,
    input  logic                            cpu_busy,
    input  logic                            cpu_done,
    output cpu_pkg::dmem_req_t              host_req,
    output logic                            cpu_start
);

    host_pkg::host_state_e            state;
    logic [1:0]                       byte_idx;
    logic [1:0]                       last_idx;
    logic                             bad_cmd;
    logic [host_pkg::byte_width-1:0]  cycles;
    logic [cpu_pkg::data_width-1:0]   arg;
    host_pkg::host_report_t           report;

    ////////////////////////////////////////////////////////////
    // Handshakes and RAM port
    ////////////////////////////////////////////////////////////

    assign rx_ready = (state == host_pkg::hs_idle) ||
                      (state == host_pkg::hs_arg_lo) ||
                      (state == host_pkg::hs_arg_hi);
    assign tx_valid = (state == host_pkg::hs_send);

    // A rejected command answers with a single byte
    assign last_idx = bad_cmd ? 2'd0 : 2'(host_pkg::reply_bytes - 1);

    always_comb begin
        if (bad_cmd) begin
            tx_data = host_pkg::rep_bad_cmd;
        end else begin
            case (byte_idx)
                2'd0:    tx_data = report.acc[7:0];
                2'd1:    tx_data = report.acc[15:8];
                default: tx_data = report.cycles;
            endcase
        end
    end

    // Argument always goes to word 0
    always_comb begin
        host_req.addr  = '0;
        host_req.wdata = arg;
        host_req.wr    = (state == host_pkg::hs_load);
    end

    ////////////////////////////////////////////////////////////
    // Command FSM and cycle counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= host_pkg::hs_idle;
            byte_idx  <= '0;
            bad_cmd   <= 1'b0;
            cycles    <= '0;
            cpu_start <= 1'b0;
        end else begin
            cpu_start <= 1'b0;
            case (state)
                host_pkg::hs_idle: begin
                    if (rx_valid) begin
                        byte_idx <= '0;
                        if (rx_data == host_pkg::cmd_run) begin
                            bad_cmd <= 1'b0;
                            state   <= host_pkg::hs_arg_lo;
                        end else begin
                            bad_cmd <= 1'b1;
                            state   <= host_pkg::hs_send;
                        end
                    end
                end
                host_pkg::hs_arg_lo: if (rx_valid) state <= host_pkg::hs_arg_hi;
                host_pkg::hs_arg_hi: if (rx_valid) state <= host_pkg::hs_load;
                host_pkg::hs_load: begin
                    cpu_start <= 1'b1;
                    cycles    <= '0;
                    state     <= host_pkg::hs_run;
                end
                host_pkg::hs_run: begin
                    // Saturates rather than wrapping on long programs
                    if (cpu_busy && (cycles != '1)) begin
                        cycles <= cycles + 1'b1;
                    end
                    if (cpu_done) begin
                        state <= host_pkg::hs_send;
                    end
                end
                host_pkg::hs_send: begin
                    if (tx_ready) begin
                        if (byte_idx == last_idx) begin
                            state <= host_pkg::hs_idle;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: state <= host_pkg::hs_idle;
            endcase
        end
    end

    // Argument bytes arrive low first
    always_ff @(posedge clk) begin
        if ((state == host_pkg::hs_arg_lo) && rx_valid) arg[7:0] <= rx_data;
        if ((state == host_pkg::hs_arg_hi) && rx_valid) arg[15:8] <= rx_data;
        if ((state == host_pkg::hs_run) && cpu_done) begin
            report.acc    <= acc;
            report.cycles <= cycles;
        end
    end

endmodule

// ==== bip_top.sv ====
module bip_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [host_pkg::byte_width-1:0] rx_data,
    input  logic                            rx_valid,
    output logic                            rx_ready,
    output logic [host_pkg::byte_width-1:0] tx_data,
    output logic                            tx_valid,
    input  logic                            tx_ready
);

    logic [cpu_pkg::addr_width-1:0] prog_addr;
    logic [cpu_pkg::data_width-1:0] instr;
    logic [cpu_pkg::data_width-1:0] rdata;
    logic [cpu_pkg::data_width-1:0] acc;
    logic                           cpu_start;
    logic                           cpu_busy;
    logic                           cpu_done;
    cpu_pkg::dmem_req_t             cpu_req;
    cpu_pkg::dmem_req_t             host_req;
    cpu_pkg::dmem_req_t             mem_req;

    // CPU owns the data RAM only while it runs
    assign mem_req = cpu_busy ? cpu_req : host_req;

    accumulator_cpu u_cpu (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (cpu_start),
        .instr     (instr),
        .rdata     (rdata),
        .prog_addr (prog_addr),
        .dmem      (cpu_req),
        .acc       (acc),
        .busy      (cpu_busy),
        .done      (cpu_done)
    );

    program_mem u_program_mem (.clk(clk), .addr(prog_addr), .instr(instr));

    data_mem u_data_mem (.clk(clk), .req(mem_req), .rdata(rdata));

    host_interface u_host_interface (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .acc       (acc),
        .cpu_busy  (cpu_busy),
        .cpu_done  (cpu_done),
        .host_req  (host_req),
        .cpu_start (cpu_start)
    );

endmodule

// ==== bip_properties.sv ====
module bip_properties (
    input logic                            clk,
    input logic                            arst_n,
    input logic                            rx_ready,
    input logic [host_pkg::byte_width-1:0] tx_data,
    input logic                            tx_valid,
    input logic                            tx_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reply byte held under back-pressure
    property tx_held_p;
        @(posedge clk) disable iff (!arst_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data));
    endproperty

    property tx_quiet_after_reset_p;
        @(posedge clk) $rose(arst_n) |-> !tx_valid;
    endproperty

    // Link is half duplex
    property rx_tx_exclusive_p;
        @(posedge clk) disable iff (!arst_n)
        !(rx_ready && tx_valid);
    endproperty

    tx_held_a: assert property (tx_held_p)
        else $error("tx byte changed while tx_ready was low");
    tx_quiet_after_reset_a: assert property (tx_quiet_after_reset_p)
        else $error("tx_valid high in the first cycle after reset");
    rx_tx_exclusive_a: assert property (rx_tx_exclusive_p)
        else $error("rx_ready and tx_valid high together");

endmodule

bind bip_top bip_properties bip_properties_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .rx_ready (rx_ready),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
);

// ==== tb_bip_top.sv ====
module tb_bip_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_half    = 50;
    localparam int drive_delay = 10;
    localparam int max_wait    = 200;
    localparam int num_txn     = 10;
    localparam int exp_cycles  = 3 * 6;

    // One host exchange, expected bytes in send order from index 0
    typedef struct packed {
        logic [7:0]      cmd;
        logic [15:0]     arg;
        logic [1:0]      n_reply;
        logic [2:0][7:0] exp_bytes;
        logic            stall;
    } host_txn_t;

    logic       clk;
    logic       arst_n;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    integer     seed;
    host_txn_t  txn_table [num_txn];

    bip_top bip_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    always #clk_half clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("No handshake within %0d cycles while waiting for %s", max_wait, what);
        $display("SIMULATION FAILED");
        $fatal(1, "handshake timeout");
    endtask

    ////////////////////////////////////////////////////////////
    // Host link, always entered just after a clock edge
    ////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [7:0] b, input string what);
        int waited;
        waited   = 0;
        rx_data  = b;
        rx_valid = 1'b1;
        while (!rx_ready) begin
            if (waited == max_wait) report_timeout(what);
            @(posedge clk);
            #drive_delay;
            waited = waited + 1;
        end
        @(posedge clk);
        #drive_delay;
        rx_valid = 1'b0;
    endtask

    task automatic receive_byte(input logic stall, output logic [7:0] b, input string what);
        int   waited;
        logic got;
        waited = 0;
        got    = 1'b0;
        while (!got) begin
            // Random back-pressure, ready about three cycles in four
            tx_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
            check_value(rx_ready, 0, {what, " rx_ready low"});
            if (tx_valid && tx_ready) begin
                b   = tx_data;
                got = 1'b1;
            end else if (waited == max_wait) begin
                report_timeout(what);
            end
            @(posedge clk);
            #drive_delay;
            waited = waited + 1;
        end
        tx_ready = 1'b0;
    endtask

    task automatic run_transaction(input host_txn_t t, input int idx);
        logic [7:0] b;
        string      tag;
        int         i;
        tag = $sformatf("txn %0d", idx);
        send_byte(t.cmd, {tag, " command"});
        if (t.cmd == host_pkg::cmd_run) begin
            send_byte(t.arg[7:0], {tag, " arg low"});
            send_byte(t.arg[15:8], {tag, " arg high"});
        end
        for (i = 0; i < int'(t.n_reply); i++) begin
            receive_byte(t.stall, b, $sformatf("%s reply %0d", tag, i));
            check_value(b, t.exp_bytes[i], $sformatf("%s reply byte %0d", tag, i));
        end
        // Nothing more pending, link back to accepting commands
        check_value(tx_valid, 0, {tag, " extra reply byte"});
        check_value(rx_ready, 1, {tag, " rx_ready after reply"});
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    // Program returns 2a+7 and runs six instructions
    function automatic host_txn_t make_run(input logic [15:0] arg, input logic stall);
        host_txn_t   t;
        logic [15:0] result;
        result         = arg + arg + 16'd7;
        t.cmd          = host_pkg::cmd_run;
        t.arg          = arg;
        t.n_reply      = 2'd3;
        t.exp_bytes[0] = result[7:0];
        t.exp_bytes[1] = result[15:8];
        t.exp_bytes[2] = 8'(exp_cycles);
        t.stall        = stall;
        return t;
    endfunction

    function automatic host_txn_t make_bad(input logic [7:0] cmd, input logic stall);
        host_txn_t t;
        t              = '0;
        t.cmd          = cmd;
        t.n_reply      = 2'd1;
        t.exp_bytes[0] = host_pkg::rep_bad_cmd;
        t.stall        = stall;
        return t;
    endfunction

    initial begin
        int idx;
        seed     = 32'h9f3e;
        clk      = 1'b0;
        arst_n   = 1'b0;
        rx_data  = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;

        txn_table[0] = '{cmd: 8'h52, arg: 16'h0004, n_reply: 2'd3,
                         exp_bytes: {8'd18, 8'h00, 8'h0F}, stall: 1'b0};
        txn_table[1] = make_run(16'h0000, 1'b0);
        txn_table[2] = make_run(16'h7FF0, 1'b0);
        txn_table[3] = make_run(16'hFFFF, 1'b0);
        txn_table[4] = make_bad(8'h41, 1'b0);
        txn_table[5] = make_run(16'h1234, 1'b0);
        txn_table[6] = make_run(16'h0100, 1'b1);
        txn_table[7] = make_run(16'hABCD, 1'b1);
        txn_table[8] = make_bad(8'h00, 1'b1);
        txn_table[9] = make_run(16'h0042, 1'b1);

        repeat (2) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;
        check_value(tx_valid, 0, "tx_valid after reset");
        check_value(rx_ready, 1, "rx_ready after reset");

        for (idx = 0; idx < num_txn; idx++) begin
            run_transaction(txn_table[idx], idx);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== program.hex ====
// opcode[15:11] operand[10:0], one instruction per line
1000
2805
0801
2001
3803
0000

// ==== verilog.f ====
cpu_pkg.sv
host_pkg.sv
accumulator_cpu.sv
program_mem.sv
data_mem.sv
host_interface.sv
bip_top.sv
bip_properties.sv
tb_bip_top.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_bip_top
FILELIST   = verilog.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
SIM_BIN    = ./obj_dir/V$(TOP)
PASS_MSG   = SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
